// ==== bench/nice_core_assertions.sv ====
module nice_core_assertions (
   input logic                      nice_clk,
   input logic                      rst_n,
   input logic                      nice_icb_cmd_valid,
   input logic                      nice_icb_cmd_ready,
   input nice_core_pkg::nice_word_t nice_icb_cmd_addr,
   input logic                      nice_rsp_valid,
   input logic                      nice_rsp_ready
);
   timeunit 1ns;
   timeprecision 1ps;

   // number of failed assertions so far
   int fail_cnt;

   ////////////////////////////////////////
   // port protocol rules
   ////////////////////////////////////////

   // nothing leaves the core while reset is applied
   assert property (@(posedge nice_clk) !rst_n |=> !nice_icb_cmd_valid && !nice_rsp_valid)
      else begin
         fail_cnt++;
         $error("command or response valid while in reset");
      end

   // a stalled command keeps its address
   assert property (@(posedge nice_clk) disable iff (!rst_n)
      nice_icb_cmd_valid && !nice_icb_cmd_ready |=>
         nice_icb_cmd_valid && $stable(nice_icb_cmd_addr))
      else begin
         fail_cnt++;
         $error("command address changed while stalled");
      end

   // word accesses only
   assert property (@(posedge nice_clk) disable iff (!rst_n)
      nice_icb_cmd_valid |-> nice_icb_cmd_addr[1:0] == 2'b00)
      else begin
         fail_cnt++;
         $error("command address not word aligned");
      end

   // the response waits for the main core
   assert property (@(posedge nice_clk) disable iff (!rst_n)
      nice_rsp_valid && !nice_rsp_ready |=> nice_rsp_valid)
      else begin
         fail_cnt++;
         $error("response valid dropped before ready");
      end

endmodule

bind nice_core nice_core_assertions u_assertions (
   .nice_clk           (nice_clk),
   .rst_n              (rst_n),
   .nice_icb_cmd_valid (nice_icb_cmd_valid),
   .nice_icb_cmd_ready (nice_icb_cmd_ready),
   .nice_icb_cmd_addr  (nice_icb_cmd_addr),
   .nice_rsp_valid     (nice_rsp_valid),
   .nice_rsp_ready     (nice_rsp_ready)
);

// ==== bench/tb_nice_core.sv ====
`include "nice_cfg.svh"

module tb_nice_core;
   timeunit 1ns;
   timeprecision 1ps;

   import nice_isa_pkg::*;
   import nice_core_pkg::*;

   localparam int TIMEOUT   = 200;
   localparam int MEM_WORDS = 256;

   logic       nice_clk = 1'b0;
   logic       rst_n;
   logic       nice_req_valid;
   logic       nice_req_ready;
   nice_word_t nice_req_inst;
   nice_word_t nice_req_rs1;
   nice_word_t nice_req_rs2;
   logic       nice_rsp_valid;
   logic       nice_rsp_ready;
   nice_word_t nice_rsp_rdat;
   logic       nice_rsp_err;
   logic       nice_icb_cmd_valid;
   logic       nice_icb_cmd_ready;
   nice_word_t nice_icb_cmd_addr;
   logic       nice_icb_cmd_read;
   nice_word_t nice_icb_cmd_wdata;
   logic       nice_icb_rsp_valid;
   logic       nice_icb_rsp_ready;
   nice_word_t nice_icb_rsp_rdata;
   logic       nice_icb_rsp_err;
   logic       nice_active;
   logic       nice_mem_holdup;

   int         seed;
   // index of the command answered with an error (-1 for none)
   int         err_at;
   nice_word_t mem [MEM_WORDS];
   // expected row buffer contents
   nice_word_t exp_row [`NICE_COL_NUM];
   // accepted commands in arrival order
   nice_word_t log_addr [$];
   nice_word_t log_wdata [$];
   logic       log_read [$];
   // responses still owed by the memory
   nice_word_t rsp_data_q [$];
   logic       rsp_err_q [$];

   nice_core dut (.*);

   always #5 nice_clk = ~nice_clk;

   ////////////////////////////////////////
   // checks and failure
   ////////////////////////////////////////
   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input nice_word_t got, input nice_word_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at %0t ns: %s did not come within %0d cycles", $time, what, TIMEOUT);
      abort_run();
   endtask

   ////////////////////////////////////////
   // memory model
   ////////////////////////////////////////
   function automatic int word_index(input nice_word_t addr);
      return int'(addr[9:2]);
   endfunction

   // random command readiness and in-order answers after a random delay
   task automatic serve_memory();
      logic pending;
      pending = 1'b0;
      forever begin
         @(negedge nice_clk);
         nice_icb_cmd_ready = rst_n & (($random(seed) & 3) != 0);
         if (!pending && rsp_data_q.size() > 0 && ($random(seed) & 1) == 1) begin
            pending = 1'b1;
         end
         // a raised response keeps the queue head until taken
         nice_icb_rsp_valid = pending;
         nice_icb_rsp_rdata = pending ? rsp_data_q[0] : '0;
         nice_icb_rsp_err   = pending ? rsp_err_q[0] : 1'b0;
         // handshakes are settled 1 ns before the rising edge
         #4;
         if (nice_icb_cmd_valid && nice_icb_cmd_ready) begin
            rsp_err_q.push_back(log_addr.size() == err_at);
            if (nice_icb_cmd_read) begin
               rsp_data_q.push_back(mem[word_index(nice_icb_cmd_addr)]);
            end else begin
               mem[word_index(nice_icb_cmd_addr)] = nice_icb_cmd_wdata;
               rsp_data_q.push_back('0);
            end
            log_addr.push_back(nice_icb_cmd_addr);
            log_read.push_back(nice_icb_cmd_read);
            log_wdata.push_back(nice_icb_cmd_wdata);
         end
         if (nice_icb_rsp_valid && nice_icb_rsp_ready) begin
            void'(rsp_data_q.pop_front());
            void'(rsp_err_q.pop_front());
            pending = 1'b0;
         end
      end
   endtask

   ////////////////////////////////////////
   // request and response handling
   ////////////////////////////////////////
   function automatic nice_word_t make_inst(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [6:0] opc);
      // rd x3, rs1 x1, rs2 x2
      return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
   endfunction

   task automatic raise_req(input nice_word_t inst, input nice_word_t rs1);
      @(negedge nice_clk);
      nice_req_valid = 1'b1;
      nice_req_inst  = inst;
      nice_req_rs1   = rs1;
      nice_req_rs2   = ~rs1;
   endtask

   // called on a falling edge and returns after the transfer
   task automatic finish_req();
      int n;
      n = 0;
      #4;
      while (!nice_req_ready) begin
         if (n >= TIMEOUT) report_timeout("nice_req_ready");
         n++;
         @(negedge nice_clk);
         #4;
      end
      @(negedge nice_clk);
      nice_req_valid = 1'b0;
   endtask

   task automatic wait_rsp(output nice_word_t rdat, output logic err);
      int n;
      n = 0;
      @(negedge nice_clk);
      #4;
      while (!nice_rsp_valid) begin
         if (n >= TIMEOUT) report_timeout("nice_rsp_valid");
         n++;
         @(negedge nice_clk);
         #4;
      end
      rdat = nice_rsp_rdat;
      err  = nice_rsp_err;
   endtask

   // stalls the response and then takes it
   task automatic release_rsp(input int hold, input nice_word_t rdat, input logic err);
      repeat (hold) begin
         @(negedge nice_clk);
         #4;
         check_bit("nice_rsp_valid", nice_rsp_valid, 1'b1);
         check_word("nice_rsp_rdat", nice_rsp_rdat, rdat);
         check_bit("nice_rsp_err", nice_rsp_err, err);
         check_bit("nice_req_ready", nice_req_ready, 1'b0);
         check_bit("nice_active", nice_active, 1'b1);
         check_bit("nice_mem_holdup", nice_mem_holdup, 1'b1);
      end
      @(negedge nice_clk);
      nice_rsp_ready = 1'b1;
      #4;
      check_bit("nice_rsp_valid", nice_rsp_valid, 1'b1);
      check_bit("nice_active", nice_active, 1'b1);
      check_bit("nice_mem_holdup", nice_mem_holdup, 1'b1);
      @(negedge nice_clk);
      nice_rsp_ready = 1'b0;
   endtask

   task automatic clear_log();
      log_addr.delete();
      log_read.delete();
      log_wdata.delete();
   endtask

   task automatic check_cmd_log(input nice_word_t rs1, input logic read);
      check_word("command count", nice_word_t'(log_addr.size()), nice_word_t'(`NICE_COL_NUM));
      for (int i = 0; i < `NICE_COL_NUM; i++) begin
         check_word("nice_icb_cmd_addr", log_addr[i], rs1 + nice_word_t'(`NICE_ADDR_STEP * i));
         check_bit("nice_icb_cmd_read", log_read[i], read);
      end
   endtask

   // scalar sum of one row wrapping at 32 bits
   function automatic nice_word_t row_sum(input nice_word_t rs1);
      nice_word_t s;
      s = '0;
      for (int i = 0; i < `NICE_COL_NUM; i++) begin
         s = s + mem[word_index(rs1) + i];
      end
      return s;
   endfunction

   task automatic add_row(input nice_word_t rs1);
      for (int i = 0; i < `NICE_COL_NUM; i++) begin
         exp_row[i] = exp_row[i] + mem[word_index(rs1) + i];
      end
   endtask

   task automatic run_rowsum(input nice_word_t rs1, input int hold, input logic exp_err);
      nice_word_t exp_sum;
      nice_word_t rdat;
      logic       err;
      exp_sum = row_sum(rs1);
      add_row(rs1);
      clear_log();
      raise_req(make_inst(F7_ROWSUM, F3_ROWSUM, OPC_CUSTOM3), rs1);
      finish_req();
      wait_rsp(rdat, err);
      release_rsp(hold, rdat, err);
      check_word("nice_rsp_rdat", rdat, exp_sum);
      check_bit("nice_rsp_err", err, exp_err);
      check_cmd_log(rs1, 1'b1);
   endtask

   task automatic run_sbuf(input nice_word_t rs1, input int hold, input logic exp_err);
      nice_word_t rdat;
      logic       err;
      clear_log();
      raise_req(make_inst(F7_SBUF, F3_SBUF, OPC_CUSTOM3), rs1);
      finish_req();
      wait_rsp(rdat, err);
      release_rsp(hold, rdat, err);
      check_word("nice_rsp_rdat", rdat, '0);
      check_bit("nice_rsp_err", err, exp_err);
      check_cmd_log(rs1, 1'b0);
      for (int i = 0; i < `NICE_COL_NUM; i++) begin
         check_word("nice_icb_cmd_wdata", log_wdata[i], exp_row[i]);
      end
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////
   task automatic sbuf_zero_after_reset();
      run_sbuf(32'h0000_0300, 0, 1'b0);
   endtask

   // row buffer holds column sums of both rows
   task automatic two_rows_then_store();
      run_rowsum(32'h0000_0040, 0, 1'b0);
      run_rowsum(32'h0000_0124, 1, 1'b0);
      run_sbuf(32'h0000_0310, 0, 1'b0);
   endtask

   task automatic rowsum_basic();
      run_rowsum(32'h0000_0000, 0, 1'b0);
      run_rowsum(32'h0000_03f0, 2, 1'b0);
   endtask

   task automatic error_per_beat();
      for (int b = 0; b < `NICE_COL_NUM; b++) begin
         err_at = b;
         run_rowsum(32'h0000_0080, 0, 1'b1);
         err_at = -1;
         run_rowsum(32'h0000_0090, 0, 1'b0);
      end
      // last sbuf beat is the one held back
      err_at = `NICE_COL_NUM - 1;
      run_sbuf(32'h0000_0380, 3, 1'b1);
      err_at = 0;
      run_sbuf(32'h0000_0380, 0, 1'b1);
      err_at = -1;
      run_sbuf(32'h0000_0380, 0, 1'b0);
   endtask

   task automatic illegal_dropped();
      clear_log();
      // old lbuf encoding
      raise_req(make_inst(7'b0000001, 3'b110, OPC_CUSTOM3), 32'h0000_0100);
      finish_req();
      // custom-0 opcode
      raise_req(make_inst(F7_ROWSUM, F3_ROWSUM, 7'b0001011), 32'h0000_0100);
      finish_req();
      repeat (6) begin
         @(negedge nice_clk);
         #4;
         check_bit("nice_rsp_valid", nice_rsp_valid, 1'b0);
         check_bit("nice_icb_cmd_valid", nice_icb_cmd_valid, 1'b0);
      end
      check_bit("nice_active", nice_active, 1'b0);
      check_bit("nice_mem_holdup", nice_mem_holdup, 1'b0);
      check_word("command count", nice_word_t'(log_addr.size()), '0);
   endtask

   // second request waits behind a stalled response
   task automatic stalled_response();
      nice_word_t sum_a;
      nice_word_t sum_b;
      nice_word_t rdat;
      logic       err;
      int         hold;
      hold  = 2 + ($random(seed) & 7);
      sum_a = row_sum(32'h0000_00c0);
      sum_b = row_sum(32'h0000_01a8);
      add_row(32'h0000_00c0);
      add_row(32'h0000_01a8);
      raise_req(make_inst(F7_ROWSUM, F3_ROWSUM, OPC_CUSTOM3), 32'h0000_00c0);
      finish_req();
      wait_rsp(rdat, err);
      raise_req(make_inst(F7_ROWSUM, F3_ROWSUM, OPC_CUSTOM3), 32'h0000_01a8);
      release_rsp(hold, rdat, err);
      check_word("nice_rsp_rdat", rdat, sum_a);
      check_bit("nice_rsp_err", err, 1'b0);
      finish_req();
      wait_rsp(rdat, err);
      release_rsp(0, rdat, err);
      check_word("nice_rsp_rdat", rdat, sum_b);
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      seed               = 92789;
      err_at             = -1;
      rst_n              = 1'b0;
      nice_req_valid     = 1'b0;
      nice_req_inst      = '0;
      nice_req_rs1       = '0;
      nice_req_rs2       = '0;
      nice_rsp_ready     = 1'b0;
      nice_icb_cmd_ready = 1'b0;
      nice_icb_rsp_valid = 1'b0;
      nice_icb_rsp_rdata = '0;
      nice_icb_rsp_err   = 1'b0;
      // large values so row sums wrap
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = nice_word_t'(i) * 32'h9e37_79b1 + 32'hc3a5_0f17;
      end
      for (int i = 0; i < `NICE_COL_NUM; i++) begin
         exp_row[i] = '0;
      end
      fork
         serve_memory();
      join_none
      repeat (2) @(posedge nice_clk);
      @(negedge nice_clk);
      rst_n = 1'b1;
      #4;
      check_bit("nice_rsp_valid", nice_rsp_valid, 1'b0);
      check_bit("nice_icb_cmd_valid", nice_icb_cmd_valid, 1'b0);
      check_bit("nice_active", nice_active, 1'b0);
      check_bit("nice_mem_holdup", nice_mem_holdup, 1'b0);
      sbuf_zero_after_reset();
      two_rows_then_store();
      rowsum_basic();
      error_per_beat();
      illegal_dropped();
      stalled_response();
      // bound protocol checks count their own failures
      if (dut.u_assertions.fail_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== include/nice_cfg.svh ====
`ifndef NICE_CFG_SVH
`define NICE_CFG_SVH

// data and address width of the core
`define NICE_XLEN 32

// number of row buffer entries
`define NICE_ROWBUF_DP 4

// words moved by one rowsum or sbuf
// must stay at or below NICE_ROWBUF_DP
`define NICE_COL_NUM 3

// byte step between consecutive memory beats
`define NICE_ADDR_STEP 4

`endif

// ==== nice_core.f ====
+incdir+include
src/nice_isa_pkg.sv
src/nice_core_pkg.sv
src/nice_beat_if.sv
src/nice_ctrl.sv
src/nice_icb_seq.sv
src/nice_row_buf.sv
src/nice_core.sv
bench/nice_core_assertions.sv
bench/tb_nice_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f nice_core.f --top-module tb_nice_core

out=$(./obj_dir/Vtb_nice_core 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
exit 1

// ==== src/nice_beat_if.sv ====
interface nice_beat_if;
   import nice_core_pkg::*;

   // one accepted memory response of rowsum
   logic       beat_valid;
   nice_idx_t  beat_idx;
   nice_word_t beat_data;
   logic       beat_last;

   // sequencer side, drives one strobe per beat
   modport seq (
      output beat_valid,
      output beat_idx,
      output beat_data,
      output beat_last
   );

   // row buffer side, no back-pressure
   modport rbuf (
      input beat_valid,
      input beat_idx,
      input beat_data,
      input beat_last
   );

endinterface

// ==== src/nice_core.sv ====
module nice_core (
   input  logic                      nice_clk,
   input  logic                      rst_n,
   // request from the main core
   input  logic                      nice_req_valid,
   output logic                      nice_req_ready,
   input  nice_core_pkg::nice_word_t nice_req_inst,
   input  nice_core_pkg::nice_word_t nice_req_rs1,
   // rs2 is not read by rowsum or sbuf
   input  nice_core_pkg::nice_word_t nice_req_rs2,
   // response to the main core
   output logic                      nice_rsp_valid,
   input  logic                      nice_rsp_ready,
   output nice_core_pkg::nice_word_t nice_rsp_rdat,
   output logic                      nice_rsp_err,
   // memory command
   output logic                      nice_icb_cmd_valid,
   input  logic                      nice_icb_cmd_ready,
   output nice_core_pkg::nice_word_t nice_icb_cmd_addr,
   output logic                      nice_icb_cmd_read,
   output nice_core_pkg::nice_word_t nice_icb_cmd_wdata,
   // memory response
   input  logic                      nice_icb_rsp_valid,
   output logic                      nice_icb_rsp_ready,
   input  nice_core_pkg::nice_word_t nice_icb_rsp_rdata,
   input  logic                      nice_icb_rsp_err,
   // status
   output logic                      nice_active,
   output logic                      nice_mem_holdup
);
   import nice_isa_pkg::*;
   import nice_core_pkg::*;

   ////////////////////////////////////////
   // internal wiring
   ////////////////////////////////////////
   nice_state_e state;
   nice_op_e    op;
   logic        start;
   logic        op_last_rsp;
   // sbuf reads the row buffer through these
   nice_idx_t   wr_idx;
   nice_word_t  wr_data;
   // rowsum result back to the control
   nice_word_t  sum;
   logic        sum_valid;

   // memory beats from sequencer to row buffer
   nice_beat_if beat ();

   ////////////////////////////////////////
   // instances
   ////////////////////////////////////////
   // decode, FSM and response
   nice_ctrl u_ctrl (.*);

   // memory command and response side
   nice_icb_seq u_icb_seq (.*);

   // row registers and accumulator
   nice_row_buf u_row_buf (.*);

endmodule

// ==== src/nice_core_pkg.sv ====
`include "nice_cfg.svh"

package nice_core_pkg;

   ////////////////////////////////////////
   // shared datapath and control types
   ////////////////////////////////////////

   // FSM state, one per multi-cycle instruction
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ROWSUM,
      ST_SBUF
   } nice_state_e;

   // data or address word
   typedef logic [`NICE_XLEN-1:0] nice_word_t;

   // index into the row buffer
   typedef logic [$clog2(`NICE_ROWBUF_DP)-1:0] nice_idx_t;

endpackage

// ==== src/nice_ctrl.sv ====
module nice_ctrl (
   input  logic                       nice_clk,
   input  logic                       rst_n,
   // request side
   input  logic                       nice_req_valid,
   input  nice_core_pkg::nice_word_t  nice_req_inst,
   output logic                       nice_req_ready,
   // memory handshake, watched for acceptance and response timing
   input  logic                       nice_icb_cmd_ready,
   input  logic                       nice_icb_rsp_valid,
   input  logic                       nice_icb_rsp_ready,
   input  logic                       nice_icb_rsp_err,
   input  logic                       op_last_rsp,
   // rowsum result
   input  nice_core_pkg::nice_word_t  sum,
   input  logic                       sum_valid,
   // response side
   input  logic                       nice_rsp_ready,
   output logic                       nice_rsp_valid,
   output nice_core_pkg::nice_word_t  nice_rsp_rdat,
   output logic                       nice_rsp_err,
   // control to the sequencer and row buffer
   output nice_core_pkg::nice_state_e state,
   output nice_isa_pkg::nice_op_e     op,
   output logic                       start,
   output logic                       nice_active,
   output logic                       nice_mem_holdup
);
   import nice_isa_pkg::*;
   import nice_core_pkg::*;

   logic state_idle;
   logic req_hsk;
   logic rsp_hsk;
   logic icb_rsp_hsk;
   logic sbuf_last_valid;
   logic err_r;

   ////////////////////////////////////////
   // decode
   ////////////////////////////////////////
   always_comb begin
      op = OP_NONE;
      if (nice_req_inst[6:0] == OPC_CUSTOM3) begin
         if (nice_req_inst[14:12] == F3_ROWSUM && nice_req_inst[31:25] == F7_ROWSUM) begin
            op = OP_ROWSUM;
         end else if (nice_req_inst[14:12] == F3_SBUF && nice_req_inst[31:25] == F7_SBUF) begin
            op = OP_SBUF;
         end
      end
   end

   assign state_idle = (state == ST_IDLE);

   // memory ops need the command port free, illegal ones drop through
   assign nice_req_ready = state_idle & ((op == OP_NONE) | nice_icb_cmd_ready);
   assign req_hsk        = nice_req_valid & nice_req_ready;
   assign start          = req_hsk & (op != OP_NONE);

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else if (start) begin
         state <= (op == OP_ROWSUM) ? ST_ROWSUM : ST_SBUF;
      end else if (rsp_hsk) begin
         // both ops end on the core response transfer
         state <= ST_IDLE;
      end
   end

   ////////////////////////////////////////
   // response
   ////////////////////////////////////////
   assign icb_rsp_hsk = nice_icb_rsp_valid & nice_icb_rsp_ready;

   // last sbuf beat is either taken now or stalled by the sequencer
   assign sbuf_last_valid = (state == ST_SBUF)
                          & (op_last_rsp | (nice_icb_rsp_valid & ~nice_icb_rsp_ready));

   always_comb begin
      case (state)
         ST_ROWSUM: nice_rsp_valid = sum_valid;
         ST_SBUF:   nice_rsp_valid = sbuf_last_valid;
         default:   nice_rsp_valid = 1'b0;
      endcase
   end

   assign rsp_hsk       = nice_rsp_valid & nice_rsp_ready;
   // sbuf answers with zero
   assign nice_rsp_rdat = (state == ST_ROWSUM) ? sum : '0;

   // sticky bus error, collected over all beats of one op
   always_ff @(posedge nice_clk) begin
      if (!rst_n) begin
         err_r <= 1'b0;
      end else if (rsp_hsk) begin
         err_r <= 1'b0;
      end else if (!state_idle && icb_rsp_hsk && nice_icb_rsp_err) begin
         err_r <= 1'b1;
      end
   end

   // the held last sbuf beat adds its own error directly
   assign nice_rsp_err = nice_rsp_valid & (err_r | (sbuf_last_valid & nice_icb_rsp_err));

   // activity flags toward the main core
   assign nice_active     = state_idle ? nice_req_valid : 1'b1;
   assign nice_mem_holdup = ~state_idle;

endmodule

// ==== src/nice_icb_seq.sv ====
`include "nice_cfg.svh"

module nice_icb_seq (
   input  logic                       nice_clk,
   input  logic                       rst_n,
   input  nice_core_pkg::nice_state_e state,
   input  nice_isa_pkg::nice_op_e     op,
   input  logic                       start,
   input  logic                       nice_req_valid,
   input  nice_core_pkg::nice_word_t  nice_req_rs1,
   input  logic                       nice_rsp_ready,
   // memory command
   output logic                       nice_icb_cmd_valid,
   input  logic                       nice_icb_cmd_ready,
   output nice_core_pkg::nice_word_t  nice_icb_cmd_addr,
   output logic                       nice_icb_cmd_read,
   output nice_core_pkg::nice_word_t  nice_icb_cmd_wdata,
   // memory response
   input  logic                       nice_icb_rsp_valid,
   output logic                       nice_icb_rsp_ready,
   input  nice_core_pkg::nice_word_t  nice_icb_rsp_rdata,
   // row buffer read port for sbuf
   output nice_core_pkg::nice_idx_t   wr_idx,
   input  nice_core_pkg::nice_word_t  wr_data,
   output logic                       op_last_rsp,
   nice_beat_if.seq                   beat
);
   import nice_isa_pkg::*;
   import nice_core_pkg::*;

   localparam int unsigned CNT_W = $clog2(`NICE_COL_NUM + 1);

   logic [CNT_W-1:0] cmd_cnt;
   logic [CNT_W-1:0] rsp_cnt;
   nice_word_t       addr_r;
   logic             state_idle;
   logic             cmd_hsk;
   logic             rsp_hsk;
   logic             rsp_last;

   assign state_idle = (state == ST_IDLE);
   assign cmd_hsk    = nice_icb_cmd_valid & nice_icb_cmd_ready;
   assign rsp_hsk    = nice_icb_rsp_valid & nice_icb_rsp_ready;
   assign rsp_last   = (rsp_cnt == CNT_W'(`NICE_COL_NUM - 1));

   ////////////////////////////////////////
   // command issue
   ////////////////////////////////////////
   always_comb begin
      if (state_idle) begin
         // column 0 leaves together with the request
         nice_icb_cmd_valid = nice_req_valid & (op != OP_NONE);
         nice_icb_cmd_addr  = nice_req_rs1;
         nice_icb_cmd_read  = (op == OP_ROWSUM);
         wr_idx             = '0;
      end else begin
         nice_icb_cmd_valid = (cmd_cnt < CNT_W'(`NICE_COL_NUM));
         nice_icb_cmd_addr  = addr_r;
         nice_icb_cmd_read  = (state == ST_ROWSUM);
         wr_idx             = nice_idx_t'(cmd_cnt);
      end
   end

   // reads carry no data
   assign nice_icb_cmd_wdata = nice_icb_cmd_read ? '0 : wr_data;

   // commands accepted so far
   always_ff @(posedge nice_clk) begin
      if (!rst_n) begin
         cmd_cnt <= '0;
      end else if (start) begin
         cmd_cnt <= CNT_W'(1);
      end else if (!state_idle && cmd_hsk) begin
         cmd_cnt <= cmd_cnt + 1'b1;
      end
   end

   // address of the next command
   always_ff @(posedge nice_clk) begin
      if (start) begin
         addr_r <= nice_req_rs1 + nice_word_t'(`NICE_ADDR_STEP);
      end else if (!state_idle && cmd_hsk) begin
         addr_r <= addr_r + nice_word_t'(`NICE_ADDR_STEP);
      end
   end

   ////////////////////////////////////////
   // response tracking
   ////////////////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (!rst_n) begin
         rsp_cnt <= '0;
      end else if (start) begin
         rsp_cnt <= '0;
      end else if (!state_idle && rsp_hsk) begin
         rsp_cnt <= rsp_cnt + 1'b1;
      end
   end

   // last sbuf beat waits for the core response to go out
   assign nice_icb_rsp_ready = ~((state == ST_SBUF) & rsp_last & ~nice_rsp_ready);
   assign op_last_rsp        = ~state_idle & rsp_hsk & rsp_last;

   // rowsum beats toward the row buffer
   assign beat.beat_valid = (state == ST_ROWSUM) & rsp_hsk;
   assign beat.beat_idx   = nice_idx_t'(rsp_cnt);
   assign beat.beat_data  = nice_icb_rsp_rdata;
   assign beat.beat_last  = rsp_last;

endmodule

// ==== src/nice_isa_pkg.sv ====
package nice_isa_pkg;

   ////////////////////////////////////////
   // custom instruction encoding
   ////////////////////////////////////////

   // only custom-3 is decoded (R type)
   typedef enum logic [6:0] {
      OPC_CUSTOM3 = 7'b1111011
   } nice_opcode_e;

   // func3 field of the kept instructions
   typedef enum logic [2:0] {
      F3_SBUF   = 3'b010,
      F3_ROWSUM = 3'b110
   } nice_func3_e;

   // func7 field of the kept instructions
   typedef enum logic [6:0] {
      F7_SBUF   = 7'b0000010,
      F7_ROWSUM = 7'b0000110
   } nice_func7_e;

   // decoded op, none also covers illegal encodings
   typedef enum logic [1:0] {
      OP_NONE,
      OP_ROWSUM,
      OP_SBUF
   } nice_op_e;

endpackage

// ==== src/nice_row_buf.sv ====
`include "nice_cfg.svh"

module nice_row_buf (
   input  logic                      nice_clk,
   input  logic                      rst_n,
   input  logic                      start,
   nice_beat_if.rbuf                 beat,
   // read port for sbuf write data
   input  nice_core_pkg::nice_idx_t  wr_idx,
   output nice_core_pkg::nice_word_t wr_data,
   // rowsum result
   output nice_core_pkg::nice_word_t sum,
   output logic                      sum_valid
);
   import nice_core_pkg::*;

   nice_word_t row_r [`NICE_ROWBUF_DP];
   logic       rcv_valid;
   logic       rcv_last;
   nice_idx_t  rcv_idx;
   nice_word_t rcv_data;
   nice_word_t acc_r;

   ////////////////////////////////////////
   // receive buffer
   ////////////////////////////////////////
   // adders below take their operand from a register, not from the bus
   always_ff @(posedge nice_clk) begin
      if (!rst_n) begin
         rcv_valid <= 1'b0;
      end else begin
         rcv_valid <= beat.beat_valid;
      end
   end

   always_ff @(posedge nice_clk) begin
      if (beat.beat_valid) begin
         rcv_idx  <= beat.beat_idx;
         rcv_data <= beat.beat_data;
         rcv_last <= beat.beat_last;
      end
   end

   ////////////////////////////////////////
   // row registers
   ////////////////////////////////////////
   // column-wise running sum over all rowsums since reset
   always_ff @(posedge nice_clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `NICE_ROWBUF_DP; i++) begin
            row_r[i] <= '0;
         end
      end else if (rcv_valid) begin
         row_r[rcv_idx] <= row_r[rcv_idx] + rcv_data;
      end
   end

   assign wr_data = row_r[wr_idx];

   ////////////////////////////////////////
   // scalar accumulator
   ////////////////////////////////////////
   // column 0 restarts the sum
   always_ff @(posedge nice_clk) begin
      if (rcv_valid) begin
         acc_r <= (rcv_idx == '0) ? rcv_data : acc_r + rcv_data;
      end
   end

   // result stays valid until the next op starts
   always_ff @(posedge nice_clk) begin
      if (!rst_n) begin
         sum_valid <= 1'b0;
      end else if (start) begin
         sum_valid <= 1'b0;
      end else if (rcv_valid && rcv_last) begin
         sum_valid <= 1'b1;
      end
   end

   assign sum = acc_r;

endmodule
